// File: tcb_mem_top.f
+incdir+hdl
+incdir+test
hdl/tcb_pkg.sv
hdl/tcb_if.sv
hdl/tcb_req_decode.sv
hdl/tcb_mem_core.sv
hdl/tcb_rsp_delay.sv
hdl/tcb_mem_top.sv
test/tcb_mem_tb.sv

// File: test/tcb_mem_tb_model.svh
// reference byte model of the two-port memory
// slot lane and select rules, expected response queues, response check

`ifndef TCB_MEM_TB_MODEL_SVH
`define TCB_MEM_TB_MODEL_SVH

// queue entry is {cycle of transfer, expected rdt}
localparam int ENT_W = 32 + `TCB_BYT*8;

tcb_byte_t        model_mem [`TCB_MEM_SIZ];
logic [ENT_W-1:0] exp_q0 [$];
logic [ENT_W-1:0] exp_q1 [$];

// lane of slot b wraps in byte-enable mode
function automatic int slot_lane(tcb_mode_t mode, tcb_adr_t adr, int b);
    if (mode == TCB_MODE_BYTE_ENA) begin
        return (int'(adr) + b) % `TCB_BYT;
    end
    return b;
endfunction

// slot takes part by its lane enable or within the first 2^siz bytes
function automatic bit slot_on(tcb_mode_t mode, tcb_adr_t adr, tcb_siz_t siz,
                               tcb_ben_t byt, int b);
    if (mode == TCB_MODE_BYTE_ENA) begin
        return byt[slot_lane(mode, adr, b)];
    end
    return b < (1 << siz);
endfunction

// expected read word with unselected lanes zero
function automatic tcb_data_t model_read(tcb_mode_t mode, tcb_adr_t adr,
                                         tcb_siz_t siz, tcb_ben_t byt);
    tcb_data_t d;
    d = '0;
    for (int b = 0; b < `TCB_BYT; b++) begin
        if (slot_on(mode, adr, siz, byt, b)) begin
            d[8*slot_lane(mode, adr, b) +: 8] = model_mem[(int'(adr) + b) % `TCB_MEM_SIZ];
        end
    end
    return d;
endfunction

task automatic model_write(tcb_mode_t mode, tcb_adr_t adr, tcb_siz_t siz,
                           tcb_ben_t byt, tcb_data_t wdt);
    for (int b = 0; b < `TCB_BYT; b++) begin
        if (slot_on(mode, adr, siz, byt, b)) begin
            model_mem[(int'(adr) + b) % `TCB_MEM_SIZ] = wdt[8*slot_lane(mode, adr, b) +: 8];
        end
    end
endtask

// one bus cycle of both ports from the driven inputs
task automatic model_cycle();
    tcb_data_t r0;
    tcb_data_t r1;
    r0 = '0;
    r1 = '0;
    // reads see contents before this cycle's writes
    if (p0_vld && !p0_wen) r0 = model_read(TCB_MODE_BYTE_ENA, p0_adr, p0_siz, p0_byt);
    if (p1_vld && !p1_wen) r1 = model_read(TCB_MODE_LOG_SIZE, p1_adr, p1_siz, p1_byt);
    if (p0_vld) exp_q0.push_back({32'(cycle), r0});
    if (p1_vld) exp_q1.push_back({32'(cycle), r1});
    // port 1 first so port 0 overwrites shared bytes
    if (p1_vld && p1_wen) model_write(TCB_MODE_LOG_SIZE, p1_adr, p1_siz, p1_byt, p1_wdt);
    if (p0_vld && p0_wen) model_write(TCB_MODE_BYTE_ENA, p0_adr, p0_siz, p0_byt, p0_wdt);
endtask

// compare one port's response against the front of its queue
task automatic check_response(int port, logic vld, tcb_data_t rdt);
    logic [ENT_W-1:0] ent;
    int               lat;
    if (vld !== 1'b0) begin
        if ((port == 0 && exp_q0.size() == 0) || (port == 1 && exp_q1.size() == 0)) begin
            errors++;
            $display("port %0d gave a response with no request outstanding in %s",
                     port, test_name);
        end else begin
            if (port == 0) ent = exp_q0.pop_front();
            else ent = exp_q1.pop_front();
            lat = cycle - int'(ent[ENT_W-1 -: 32]);
            checks++;
            if (rdt !== ent[`TCB_BYT*8-1:0]) begin
                errors++;
                $display("Fail %s port %0d rdt expected %h actual %h",
                         test_name, port, ent[`TCB_BYT*8-1:0], rdt);
            end
            if (lat != `TCB_DLY) begin
                errors++;
                $display("Fail %s port %0d latency expected %0d actual %0d",
                         test_name, port, `TCB_DLY, lat);
            end
        end
    end
endtask

`endif

// File: test/tcb_mem_tb.sv
// testbench of the two-port TCB memory
// clock, reset, LFSR stimulus, model checks and closing report

`include "tcb_macros.svh"

module tcb_mem_tb;
    import tcb_pkg::*;

    localparam int WORDS        = `TCB_MEM_SIZ / `TCB_BYT;
    localparam int IDLE_TIMEOUT = 8 * `TCB_DLY + 8;

    logic      tcb;
    logic      rst;
    logic      p0_vld;
    logic      p0_rdy;
    logic      p0_wen;
    tcb_adr_t  p0_adr;
    tcb_siz_t  p0_siz;
    tcb_ben_t  p0_byt;
    tcb_data_t p0_wdt;
    logic      p0_rsp_vld;
    tcb_data_t p0_rdt;
    logic      p1_vld;
    logic      p1_rdy;
    logic      p1_wen;
    tcb_adr_t  p1_adr;
    tcb_siz_t  p1_siz;
    tcb_ben_t  p1_byt;
    tcb_data_t p1_wdt;
    logic      p1_rsp_vld;
    tcb_data_t p1_rdt;

    int          errors;
    int          checks;
    int          cycle;
    logic [31:0] lfsr;
    string       test_name;

    `include "tcb_mem_tb_model.svh"

    tcb_mem_top UUT (
        .tcb (tcb), .rst (rst),
        .p0_vld (p0_vld), .p0_rdy (p0_rdy), .p0_wen (p0_wen), .p0_adr (p0_adr),
        .p0_siz (p0_siz), .p0_byt (p0_byt), .p0_wdt (p0_wdt),
        .p0_rsp_vld (p0_rsp_vld), .p0_rdt (p0_rdt),
        .p1_vld (p1_vld), .p1_rdy (p1_rdy), .p1_wen (p1_wen), .p1_adr (p1_adr),
        .p1_siz (p1_siz), .p1_byt (p1_byt), .p1_wdt (p1_wdt),
        .p1_rsp_vld (p1_rsp_vld), .p1_rdt (p1_rdt)
    );

    always #20 tcb = ~tcb;

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr[0]) lfsr = (lfsr >> 1) ^ 32'h8020_0003;
            else lfsr = lfsr >> 1;
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // low window or one that wraps past the top of the address space
    function automatic tcb_adr_t rand_adr();
        if (rand_bits(1)) return tcb_adr_t'(-64) + tcb_adr_t'(rand_bits(6));
        return tcb_adr_t'(16'h0100) + tcb_adr_t'(rand_bits(6));
    endfunction

    // check outputs at the falling edge before driving and modeling the next request
    task automatic issue(
        input logic      v0,
        input logic      w0,
        input tcb_adr_t  a0,
        input tcb_ben_t  e0,
        input tcb_data_t d0,
        input logic      v1,
        input logic      w1,
        input tcb_adr_t  a1,
        input tcb_siz_t  s1,
        input tcb_data_t d1
    );
        @(negedge tcb);
        cycle++;
        check_response(0, p0_rsp_vld, p0_rdt);
        check_response(1, p1_rsp_vld, p1_rdt);
        if (p0_rdy !== 1'b1) begin
            errors++;
            $display("Fail %s p0_rdy expected 1 actual %b", test_name, p0_rdy);
        end
        if (p1_rdy !== 1'b1) begin
            errors++;
            $display("Fail %s p1_rdy expected 1 actual %b", test_name, p1_rdy);
        end
        p0_vld = v0;
        p0_wen = w0;
        p0_adr = a0;
        p0_byt = e0;
        p0_wdt = d0;
        p1_vld = v1;
        p1_wen = w1;
        p1_adr = a1;
        p1_siz = s1;
        p1_wdt = d1;
        model_cycle();
    endtask

    task automatic idle_cycle();
        issue(0, 0, '0, '0, '0, 0, 0, '0, '0, '0);
    endtask

    // idle until both queues drain
    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_q0.size() > 0 || exp_q1.size() > 0) && n < IDLE_TIMEOUT) begin
            idle_cycle();
            n++;
        end
        if (exp_q0.size() > 0 || exp_q1.size() > 0) begin
            errors++;
            $display("timeout waiting for responses in %s", test_name);
            exp_q0.delete();
            exp_q1.delete();
        end
    endtask

    // both ports busy most cycles with random fields
    task automatic random_traffic(int n);
        logic      v0, w0, v1, w1;
        tcb_adr_t  a0, a1;
        tcb_ben_t  e0;
        tcb_siz_t  s1;
        tcb_data_t d0, d1;
        for (int i = 0; i < n; i++) begin
            v0 = (rand_bits(3) != 0);
            w0 = 1'(rand_bits(1));
            a0 = rand_adr();
            e0 = tcb_ben_t'(rand_bits(`TCB_BYT));
            d0 = tcb_data_t'(rand_bits(32));
            v1 = (rand_bits(3) != 0);
            w1 = 1'(rand_bits(1));
            a1 = rand_adr();
            s1 = tcb_siz_t'(rand_bits(2));
            // 4 bytes at most
            if (s1 == 2'd3) s1 = 2'd2;
            d1 = tcb_data_t'(rand_bits(32));
            issue(v0, w0, a0, e0, d0, v1, w1, a1, s1, d1);
        end
        wait_idle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        tcb = 1'b0;
        rst = 1'b1;
        lfsr = 32'd83103;
        errors = 0;
        checks = 0;
        cycle = 0;
        p0_vld = 0;
        p0_wen = 0;
        p0_adr = '0;
        p0_siz = '0;
        p0_byt = '0;
        p0_wdt = '0;
        p1_vld = 0;
        p1_wen = 0;
        p1_adr = '0;
        p1_siz = '0;
        p1_byt = '0;
        p1_wdt = '0;

        // no response during reset or the first cycles after it
        test_name = "reset";
        repeat (16) idle_cycle();
        rst = 1'b0;
        repeat (`TCB_DLY) idle_cycle();

        // contents are not reset, so write every word first
        test_name = "fill";
        for (int w = 0; w < WORDS; w++) begin
            issue(1, 1, tcb_adr_t'(w * `TCB_BYT), '1,
                  tcb_data_t'(w * 32'h0101_0101) ^ 32'h5A3C_96E1, 0, 0, '0, '0, '0);
        end
        wait_idle();

        test_name = "full_word";
        issue(1, 1, 16'h0040, '1, 32'h1357_9BDF, 0, 0, '0, '0, '0);
        issue(1, 0, 16'h0040, '1, '0, 1, 0, 16'h0040, 2'd2, '0);
        wait_idle();

        // overlapping writes followed by a read beside a write to the same bytes
        test_name = "collision";
        issue(1, 1, 16'h0081, '1, 32'hA1A2_A3A4, 1, 1, 16'h0082, 2'd2, 32'hB1B2_B3B4);
        issue(1, 1, 16'h0090, 4'h6, 32'hC1C2_C3C4, 1, 0, 16'h0090, 2'd2, '0);
        issue(1, 0, 16'h0080, '1, '0, 1, 0, 16'h0084, 2'd2, '0);
        issue(1, 0, 16'h0090, '1, '0, 1, 0, 16'h0083, 2'd1, '0);
        wait_idle();

        test_name = "random";
        random_traffic(600);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tcb_mem_tb

// File: hdl/tcb_mem_top.sv
// two-port TCB memory, top level
// port 0 in byte-enable mode, port 1 in log-size mode
// decoders, shared byte array, response delay lines

module tcb_mem_top (
    // clock and reset
    input  logic               tcb,
    input  logic               rst,
    // port 0 request
    input  logic               p0_vld,
    output logic               p0_rdy,
    input  logic               p0_wen,
    input  tcb_pkg::tcb_adr_t  p0_adr,
    input  tcb_pkg::tcb_siz_t  p0_siz,
    input  tcb_pkg::tcb_ben_t  p0_byt,
    input  tcb_pkg::tcb_data_t p0_wdt,
    // port 0 response
    output logic               p0_rsp_vld,
    output tcb_pkg::tcb_data_t p0_rdt,
    // port 1 request
    input  logic               p1_vld,
    output logic               p1_rdy,
    input  logic               p1_wen,
    input  tcb_pkg::tcb_adr_t  p1_adr,
    input  tcb_pkg::tcb_siz_t  p1_siz,
    input  tcb_pkg::tcb_ben_t  p1_byt,
    input  tcb_pkg::tcb_data_t p1_wdt,
    // port 1 response
    output logic               p1_rsp_vld,
    output tcb_pkg::tcb_data_t p1_rdt
);
    import tcb_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // port buses
    //////////////////////////////////////////////////////////////////////

    tcb_if p0_bus ();
    tcb_if p1_bus ();

    // port 0 request into the bus
    assign p0_bus.vld = p0_vld;
    assign p0_bus.wen = p0_wen;
    assign p0_bus.adr = p0_adr;
    assign p0_bus.siz = p0_siz;
    assign p0_bus.byt = p0_byt;
    assign p0_bus.wdt = p0_wdt;

    // port 1 request into the bus
    assign p1_bus.vld = p1_vld;
    assign p1_bus.wen = p1_wen;
    assign p1_bus.adr = p1_adr;
    assign p1_bus.siz = p1_siz;
    assign p1_bus.byt = p1_byt;
    assign p1_bus.wdt = p1_wdt;

    // no back-pressure on either port
    assign p0_bus.rdy = 1'b1;
    assign p1_bus.rdy = 1'b1;

    // responses out of the bus
    assign p0_rdy     = p0_bus.rdy;
    assign p0_rsp_vld = p0_bus.rsp_vld;
    assign p0_rdt     = p0_bus.rdt;
    assign p1_rdy     = p1_bus.rdy;
    assign p1_rsp_vld = p1_bus.rsp_vld;
    assign p1_rdt     = p1_bus.rdt;

    // transfer strobes
    logic p0_trn;
    logic p1_trn;

    assign p0_trn = p0_bus.vld & p0_bus.rdy;
    assign p1_trn = p1_bus.vld & p1_bus.rdy;

    //////////////////////////////////////////////////////////////////////
    // decoders and array
    //////////////////////////////////////////////////////////////////////

    mem_lane_if p0_lane ();
    mem_lane_if p1_lane ();

    // read data before the delay line
    tcb_data_t p0_rdt_raw;
    tcb_data_t p1_rdt_raw;

    tcb_req_decode #(
        .MODE (TCB_MODE_BYTE_ENA)
    ) p0_dec (
        .bus  (p0_bus),
        .lane (p0_lane),
        .rdt  (p0_rdt_raw)
    );

    tcb_req_decode #(
        .MODE (TCB_MODE_LOG_SIZE)
    ) p1_dec (
        .bus  (p1_bus),
        .lane (p1_lane),
        .rdt  (p1_rdt_raw)
    );

    // shared bytes, port 0 wins collisions
    tcb_mem_core core (
        .tcb (tcb),
        .p0  (p0_lane),
        .p1  (p1_lane)
    );

    //////////////////////////////////////////////////////////////////////
    // response delay
    //////////////////////////////////////////////////////////////////////

    tcb_rsp_delay p0_dly (
        .tcb    (tcb),
        .rst    (rst),
        .trn    (p0_trn),
        .rdt_in (p0_rdt_raw),
        .bus    (p0_bus)
    );

    tcb_rsp_delay p1_dly (
        .tcb    (tcb),
        .rst    (rst),
        .trn    (p1_trn),
        .rdt_in (p1_rdt_raw),
        .bus    (p1_bus)
    );

endmodule : tcb_mem_top

// File: hdl/tcb_rsp_delay.sv
// response delay line for one TCB port
// TCB_DLY stages of valid bit and read data word
// last stage drives the response signals

`include "tcb_macros.svh"

module tcb_rsp_delay (
    // clock and reset
    input logic                tcb,
    input logic                rst,
    // request transferred this cycle
    input logic                trn,
    // read data of the current request
    input tcb_pkg::tcb_data_t  rdt_in,
    // response side of the port
    tcb_if.sub                 bus
);
    import tcb_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // pipeline stages
    //////////////////////////////////////////////////////////////////////

    // stage 0 is loaded at the transfer edge
    logic [`TCB_DLY-1:0] vld_pipe;
    tcb_data_t           rdt_pipe [`TCB_DLY];

    // valid bits, cleared by reset
    always_ff @(posedge tcb) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= trn;
            for (int i = 1; i < `TCB_DLY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // data words, shifted every cycle
    always_ff @(posedge tcb) begin
        rdt_pipe[0] <= rdt_in;
        for (int i = 1; i < `TCB_DLY; i++) begin
            rdt_pipe[i] <= rdt_pipe[i-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    // valid the cycle after edge N+TCB_DLY-1
    assign bus.rsp_vld = vld_pipe[`TCB_DLY-1];
    assign bus.rdt     = rdt_pipe[`TCB_DLY-1];

endmodule : tcb_rsp_delay

// File: hdl/tcb_mem_core.sv
// shared byte array of the two-port memory
// two write slot sets, port 0 applied last
// two combinational read slot sets

`include "tcb_macros.svh"

module tcb_mem_core (
    // clock
    input logic     tcb,
    // port 0 slots, wins write collisions
    mem_lane_if.rsp p0,
    // port 1 slots
    mem_lane_if.rsp p1
);
    import tcb_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // contents are not reset
    tcb_byte_t mem [`TCB_MEM_SIZ];

    //////////////////////////////////////////////////////////////////////
    // writes
    //////////////////////////////////////////////////////////////////////

    // port 1 first, then port 0
    // the later assignment to the same byte takes effect
    always_ff @(posedge tcb) begin
        for (int b = 0; b < `TCB_BYT; b++) begin
            if (p1.wen[b]) begin
                mem[p1.adr[b]] <= p1.wdt[b];
            end
        end
        for (int b = 0; b < `TCB_BYT; b++) begin
            if (p0.wen[b]) begin
                mem[p0.adr[b]] <= p0.wdt[b];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reads
    //////////////////////////////////////////////////////////////////////

    // array contents before the edge
    // same-cycle write is not forwarded
    for (genvar b = 0; b < `TCB_BYT; b++) begin : gen_rd
        // port 0 slot
        assign p0.rdt[b] = mem[p0.adr[b]];
        // port 1 slot
        assign p1.rdt[b] = mem[p1.adr[b]];
    end

endmodule : tcb_mem_core

// File: hdl/tcb_req_decode.sv
// request decoder for one TCB port
// slot addresses, write enables and write bytes toward the core
// read byte reordering into response lanes

`include "tcb_macros.svh"

module tcb_req_decode #(
    // byte selection mode of this port
    parameter tcb_pkg::tcb_mode_t MODE = tcb_pkg::TCB_MODE_BYTE_ENA
)(
    // request side of the port
    tcb_if.sub               bus,
    // slots toward the core
    mem_lane_if.req          lane,
    // read data in response lane order
    output tcb_pkg::tcb_data_t rdt
);
    import tcb_pkg::*;

    // width of a lane index
    localparam int LANE_W = $clog2(`TCB_BYT);

    //////////////////////////////////////////////////////////////////////
    // per-slot mapping
    //////////////////////////////////////////////////////////////////////

    // data lane used by each slot
    logic [LANE_W-1:0]   slot_lane [`TCB_BYT];
    // slot takes part in the transfer
    logic [`TCB_BYT-1:0] slot_sel;

    for (genvar b = 0; b < `TCB_BYT; b++) begin : gen_slot
        // unwrapped byte address of this slot
        tcb_adr_t slot_adr;

        assign slot_adr = bus.adr + tcb_adr_t'(b);

        // wrap into the array
        assign lane.adr[b] = mem_adr_t'(slot_adr % `TCB_MEM_SIZ);

        if (MODE == TCB_MODE_BYTE_ENA) begin : gen_ben
            // lane wraps modulo bus width
            assign slot_lane[b] = LANE_W'(slot_adr % `TCB_BYT);
            // own enable bit per lane
            assign slot_sel[b]  = bus.byt[slot_lane[b]];
        end else begin : gen_siz
            // bytes packed from lane 0 upward
            assign slot_lane[b] = LANE_W'(b);
            // first 2^siz slots only
            assign slot_sel[b]  = (b < (1 << bus.siz));
        end

        // write strobe and byte for this slot
        assign lane.wen[b] = bus.vld & bus.wen & slot_sel[b];
        assign lane.wdt[b] = bus.wdt[slot_lane[b]*8 +: 8];
    end

    //////////////////////////////////////////////////////////////////////
    // read data
    //////////////////////////////////////////////////////////////////////

    // unselected lanes stay zero
    // zero on writes and idle cycles
    always_comb begin
        rdt = '0;
        if (bus.vld && !bus.wen) begin
            for (int b = 0; b < `TCB_BYT; b++) begin
                if (slot_sel[b]) begin
                    rdt[slot_lane[b]*8 +: 8] = lane.rdt[b];
                end
            end
        end
    end

endmodule : tcb_req_decode

// File: hdl/tcb_if.sv
// bus and memory lane interfaces
// tcb_if: one port's request and response signals
// mem_lane_if: per-slot byte access between decoder and core

`include "tcb_macros.svh"

//////////////////////////////////////////////////////////////////////
// TCB port
//////////////////////////////////////////////////////////////////////

interface tcb_if;
    import tcb_pkg::*;

    // request handshake
    logic      vld;
    logic      rdy;
    // request payload
    logic      wen;
    tcb_adr_t  adr;
    tcb_siz_t  siz;
    tcb_ben_t  byt;
    tcb_data_t wdt;
    // response
    logic      rsp_vld;
    tcb_data_t rdt;

    // requester side
    modport man (
        output vld, wen, adr, siz, byt, wdt,
        input  rdy, rsp_vld, rdt
    );

    // memory side
    modport sub (
        input  vld, wen, adr, siz, byt, wdt,
        output rdy, rsp_vld, rdt
    );

endinterface : tcb_if

//////////////////////////////////////////////////////////////////////
// memory lanes, slot b is the byte at adr+b
//////////////////////////////////////////////////////////////////////

interface mem_lane_if;
    import tcb_pkg::*;

    mem_adr_t  [`TCB_BYT-1:0] adr;
    logic      [`TCB_BYT-1:0] wen;
    tcb_byte_t [`TCB_BYT-1:0] wdt;
    tcb_byte_t [`TCB_BYT-1:0] rdt;

    // decoder side
    modport req (
        output adr, wen, wdt,
        input  rdt
    );

    // core side
    modport rsp (
        input  adr, wen, wdt,
        output rdt
    );

endinterface : mem_lane_if

// File: hdl/tcb_pkg.sv
// shared types of the TCB memory
// vector typedefs for addresses, bytes, words, enables, sizes
// byte selection mode enum

`include "tcb_macros.svh"

package tcb_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus side vectors
    //////////////////////////////////////////////////////////////////////

    // request address
    typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

    // single byte
    typedef logic [8-1:0] tcb_byte_t;

    // data word, lane b at bits [8*b +: 8]
    typedef logic [`TCB_BYT*8-1:0] tcb_data_t;

    // byte enables, one per lane
    typedef logic [`TCB_BYT-1:0] tcb_ben_t;

    // log2 of transfer size in bytes
    typedef logic [2-1:0] tcb_siz_t;

    //////////////////////////////////////////////////////////////////////
    // memory side vectors
    //////////////////////////////////////////////////////////////////////

    // byte index into the array
    typedef logic [$clog2(`TCB_MEM_SIZ)-1:0] mem_adr_t;

    // byte selection mode of a port
    typedef enum logic {
        TCB_MODE_BYTE_ENA,
        TCB_MODE_LOG_SIZE
    } tcb_mode_t;

endpackage : tcb_pkg

// File: hdl/tcb_macros.svh
// build-time constants for the TCB memory
// bus widths, memory size, response delay

`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

// request address width in bits
`define TCB_ADR_W 16

// bytes per data word, also the number of slots per port
`define TCB_BYT 4

// memory size in bytes
// byte addresses wrap modulo this size
`define TCB_MEM_SIZ 1024

// response delay in cycles, at least 1
// equals the number of response pipeline stages
`define TCB_DLY 2

`endif
